/* all.f */
mem_pkg.sv
mem_req_fifo.sv
mem_addr_gen.sv
mem_bus_master.sv
mem_ctrl_top.sv
mem_ctrl_assertions.sv
tb_mem_ctrl.sv

/* tb_mem_ctrl.sv */
// random load/store traffic through mem_ctrl_top, checked against a byte model
// segment base is fixed at 0x1000 and limit at 0xff, so the bus memory is 32 words
// ack delay is 0 to 3 cycles, resp_ready_i has random low stretches

`timescale 1ns/10ps

module tb_mem_ctrl;

	localparam int              CLK_PERIOD  = 4;
	localparam int              N_REQ       = 500;
	localparam int              WATCHDOG_NS = N_REQ * 40 * CLK_PERIOD;
	localparam logic [31:0]     SEG_BASE    = 32'h0000_1000;
	localparam logic [31:0]     SEG_LIMIT   = 32'h0000_00ff;

	logic                       clk;
	logic                       rst;
	mem_pkg::mem_req_t          req_i;
	logic                       req_wr_i;
	logic                       req_full_o;
	mem_pkg::seg_desc_t         seg_i;
	mem_pkg::bus_out_t          bus;
	logic                       ack_i;
	logic [63:0]                dat_i;
	mem_pkg::mem_resp_t         resp_o;
	logic                       resp_valid_o;
	logic                       resp_ready_i;

	logic [15:0]                lfsr;
	logic [7:0]                 model_mem [256];   // reference copy, byte per address
	logic [63:0]                bus_mem [32];      // memory behind the bus
	mem_pkg::mem_resp_t         exp_resp [$];
	mem_pkg::bus_out_t          exp_bus [$];       // adr, sel, we of each expected cycle
	int                         n_sent;
	int                         n_checked;
	int                         outstanding;
	logic                       saw_full;
	logic                       running;

	mem_ctrl_top i_mem_ctrl_top (
		.clk          (clk),
		.rst          (rst),
		.req_i        (req_i),
		.req_wr_i     (req_wr_i),
		.req_full_o   (req_full_o),
		.seg_i        (seg_i),
		.bus_o        (bus),
		.ack_i        (ack_i),
		.dat_i        (dat_i),
		.resp_o       (resp_o),
		.resp_valid_o (resp_valid_o),
		.resp_ready_i (resp_ready_i)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==================================================
	// helpers
	// ==================================================
	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// galois lfsr, one step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic int size_bytes(input mem_pkg::mem_size_e sz);
		case (sz)
			mem_pkg::SZ_B: return 1;
			mem_pkg::SZ_W: return 2;
			mem_pkg::SZ_T: return 4;
			default:       return 8;
		endcase
	endfunction

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a * 37) ^ 8'h5C;   // every address bit matters
	endfunction

	function automatic logic [4:0] word_index(input logic [31:0] adr);
		return 5'((adr - SEG_BASE) >> 3);
	endfunction

	// expected response and bus cycle of one written request
	task automatic model_request(input mem_pkg::mem_req_t r);
		int                 n;
		int                 a;
		int                 i;
		logic [63:0]        val;
		mem_pkg::mem_resp_t rsp;
		mem_pkg::bus_out_t  bx;
		n       = size_bytes(r.size);
		a       = int'(r.adr[7:0]);
		rsp.tid = r.tid;
		rsp.res = '0;
		if (r.adr > SEG_LIMIT) begin
			rsp.cause = mem_pkg::FLT_SGB;
		end else if ((a % 8) + n > 8) begin
			rsp.cause = mem_pkg::FLT_ALN;
		end else begin
			rsp.cause = mem_pkg::FLT_NONE;
			bx        = '0;
			bx.adr    = (SEG_BASE + r.adr) & ~32'h7;
			bx.we     = (r.func == mem_pkg::STORE);
			for (i = 0; i < n; i++)
				bx.sel[(a % 8) + i] = 1'b1;
			exp_bus.push_back(bx);
			if (r.func == mem_pkg::STORE) begin
				for (i = 0; i < n; i++)
					model_mem[a + i] = r.dat[8*i +: 8];
			end else begin
				val = '0;
				for (i = 0; i < n; i++)
					val[8*i +: 8] = model_mem[a + i];
				if (r.func == mem_pkg::LOAD && val[8*n-1])
					for (i = n; i < 8; i++)
						val[8*i +: 8] = 8'hFF;   // sign fill
				rsp.res = val;
			end
		end
		exp_resp.push_back(rsp);
	endtask

	// ==================================================
	// per-cycle sampling, bus responder and stimulus
	// ==================================================
	always @(posedge clk) begin : cycle_proc
		mem_pkg::mem_req_t  rq;
		mem_pkg::mem_resp_t er;
		mem_pkg::bus_out_t  bx;
		logic [4:0]         idx;
		logic               ack_now;
		logic               busy;
		int                 ack_wait;
		int                 low_cnt;
		int                 l;
		if (running) begin
			assert (i_mem_ctrl_top.i_mem_ctrl_assertions.n_fail == 0)
				else stop_on_error("a bus or response protocol assertion failed");
			assert (outstanding <= 6)
				else stop_on_error("more than six requests accepted without a response");
			if (outstanding == 6)
				assert (req_full_o) else stop_on_error(
					$sformatf("Fail %0t: req_full_o low with six requests outstanding", $time));
			if (req_full_o)
				saw_full = 1'b1;
			if (resp_valid_o && resp_ready_i) begin
				assert (exp_resp.size() != 0)
					else stop_on_error("response returned with no request outstanding");
				er = exp_resp.pop_front();
				assert (resp_o == er) else stop_on_error($sformatf(
					"Fail %0t: resp tid %0h res %h cause %0d, expected tid %0h res %h cause %0d",
					$time, resp_o.tid, resp_o.res, resp_o.cause, er.tid, er.res, er.cause));
				n_checked++;
				outstanding--;
			end
			if (req_wr_i)
				outstanding++;
			// bus responder
			ack_now = 1'b0;
			if (bus.cyc && ack_i) begin
				idx = word_index(bus.adr);
				for (l = 0; l < 8; l++)
					if (bus.we && bus.sel[l])
						bus_mem[idx][8*l +: 8] = bus.dat[8*l +: 8];
				busy = 1'b0;
			end else if (bus.cyc) begin
				if (!busy) begin
					assert (exp_bus.size() != 0)
						else stop_on_error("bus cycle started for a request that must not reach the bus");
					bx = exp_bus.pop_front();
					assert (bus.adr == bx.adr && bus.sel == bx.sel && bus.we == bx.we)
						else stop_on_error($sformatf(
						"Fail %0t: bus adr %h sel %b we %b, expected adr %h sel %b we %b",
						$time, bus.adr, bus.sel, bus.we, bx.adr, bx.sel, bx.we));
					busy     = 1'b1;
					ack_wait = int'(rand_bits(2));   // 0 to 3 cycles
				end
				if (ack_wait == 0)
					ack_now = 1'b1;
				else
					ack_wait--;
			end
			#1;
			ack_i = ack_now;
			dat_i = ack_now ? bus_mem[word_index(bus.adr)] : '0;
			if (n_sent < N_REQ && !req_full_o && rand_bits(2) != 0) begin
				case (2'(rand_bits(2)))
					2'd0:    rq.func = mem_pkg::LOAD;
					2'd1:    rq.func = mem_pkg::LOADZ;
					default: rq.func = mem_pkg::STORE;
				endcase
				rq.size = mem_pkg::mem_size_e'(2'(rand_bits(2)));
				rq.tid  = 4'(rand_bits(4));
				rq.adr  = 32'(rand_bits(8));
				if (rand_bits(1) != 0)
					rq.adr = rq.adr & ~32'(size_bytes(rq.size) - 1);   // natural alignment
				if (rand_bits(4) == 0)
					rq.adr = 32'h100 + 32'(rand_bits(8));            // beyond the limit
				rq.dat = rand_bits(64);
				model_request(rq);
				req_i    = rq;
				req_wr_i = 1'b1;
				n_sent++;
			end else begin
				req_wr_i = 1'b0;
			end
			// ready with occasional long low stretches
			if (low_cnt > 0) begin
				resp_ready_i = 1'b0;
				low_cnt--;
			end else if (rand_bits(4) == 0) begin
				resp_ready_i = 1'b0;
				low_cnt      = 4 + int'(rand_bits(4));
			end else begin
				resp_ready_i = 1'b1;
			end
		end else begin
			busy     = 1'b0;
			ack_wait = 0;
			low_cnt  = 0;
		end
	end

	// ==================================================
	// reset, run and end of test
	// ==================================================
	initial begin
		int a;
		clk          = 1'b0;
		rst          = 1'b1;
		req_i        = '0;
		req_wr_i     = 1'b0;
		seg_i.base   = SEG_BASE;
		seg_i.limit  = SEG_LIMIT;
		ack_i        = 1'b0;
		dat_i        = '0;
		resp_ready_i = 1'b0;
		lfsr         = 16'd27171;
		n_sent       = 0;
		n_checked    = 0;
		outstanding  = 0;
		saw_full     = 1'b0;
		running      = 1'b0;
		for (a = 0; a < 256; a++) begin
			model_mem[a]                  = fill_byte(a);
			bus_mem[a / 8][8*(a % 8) +: 8] = fill_byte(a);
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		assert (!bus.cyc && !bus.stb && !resp_valid_o && !req_full_o)
			else stop_on_error("bus, response or full flag not low after reset");
		#1;
		running = 1'b1;
		wait (n_checked == N_REQ);
		@(posedge clk);
		#1;
		// bus memory must match the model byte for byte
		for (a = 0; a < 256; a++)
			assert (bus_mem[a / 8][8*(a % 8) +: 8] == model_mem[a]) else stop_on_error($sformatf(
				"Fail %0t: bus memory byte %h is %h, expected %h",
				$time, a, bus_mem[a / 8][8*(a % 8) +: 8], model_mem[a]));
		if (exp_resp.size() == 0 && exp_bus.size() == 0 && saw_full && !bus.cyc
				&& i_mem_ctrl_top.i_mem_ctrl_assertions.n_fail == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			stop_on_error(
				"run ended with expected cycles pending, a protocol error or the FIFO never full");
		end
	end

	// watchdog, 40 cycles per request
	initial begin
		#(WATCHDOG_NS);
		stop_on_error("timeout before all responses arrived");
	end

endmodule

/* mem_ctrl_assertions.sv */
// bus and response protocol checks, bound into mem_ctrl_top
// assumes the responder raises ack_i only inside a cycle

`timescale 1ns/10ps

module mem_ctrl_assertions (
	input logic                 clk,
	input logic                 rst,
	input mem_pkg::bus_out_t    bus_i,
	input logic                 ack_i,
	input mem_pkg::mem_resp_t   resp_i,
	input logic                 resp_valid_i,
	input logic                 resp_ready_i
);

	int unsigned n_fail = 0;

	// ==================================================
	// bus
	// ==================================================
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst) bus_i.stb |-> bus_i.cyc)
		else begin
			$error("stb high outside a bus cycle");
			n_fail++;
		end

	cyc_until_ack: assert property (@(posedge clk) disable iff (rst)
		bus_i.cyc && !ack_i |=> bus_i.cyc && bus_i.stb && $stable(bus_i.adr))
		else begin
			$error("bus cycle dropped or changed before ack");
			n_fail++;
		end

	cyc_ends_on_ack: assert property (@(posedge clk) disable iff (rst)
		bus_i.cyc && ack_i |=> !bus_i.cyc)   // single cycle per op
		else begin
			$error("cyc still high after ack");
			n_fail++;
		end

	// ==================================================
	// response
	// ==================================================
	resp_held: assert property (@(posedge clk) disable iff (rst)
		resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
		else begin
			$error("response changed or withdrawn while waiting for ready");
			n_fail++;
		end

endmodule

bind mem_ctrl_top mem_ctrl_assertions i_mem_ctrl_assertions (
	.clk          (clk),
	.rst          (rst),
	.bus_i        (bus_o),
	.ack_i        (ack_i),
	.resp_i       (resp_o),
	.resp_valid_i (resp_valid_o),
	.resp_ready_i (resp_ready_i)
);

/* mem_ctrl_top.sv */
// data-side memory request controller: request FIFO, address stage, bus master
// responses come back in request order, one bus cycle per non-faulted request
// seg_i must be held stable while requests are pending

`timescale 1ns/10ps

module mem_ctrl_top (
	input  logic                        clk,
	input  logic                        rst,
	input  mem_pkg::mem_req_t           req_i,
	input  logic                        req_wr_i,
	output logic                        req_full_o,
	input  mem_pkg::seg_desc_t          seg_i,
	output mem_pkg::bus_out_t           bus_o,
	input  logic                        ack_i,
	input  logic [mem_pkg::DAT_W-1:0]   dat_i,
	output mem_pkg::mem_resp_t          resp_o,
	output logic                        resp_valid_o,
	input  logic                        resp_ready_i
);

	mem_pkg::mem_req_t head;
	logic              head_valid;
	logic              pop;
	mem_pkg::bus_op_t  op;
	logic              op_valid;
	logic              op_ready;

	// ==================================================
	// buffer, producer, consumer
	// ==================================================
	mem_req_fifo i_mem_req_fifo (
		.clk          (clk),
		.rst          (rst),
		.wr_i         (req_wr_i),
		.din_i        (req_i),
		.full_o       (req_full_o),
		.rd_i         (pop),
		.dout_o       (head),
		.valid_o      (head_valid)
	);

	mem_addr_gen i_mem_addr_gen (
		.clk          (clk),
		.rst          (rst),
		.head_i       (head),
		.head_valid_i (head_valid),
		.pop_o        (pop),
		.seg_i        (seg_i),
		.op_o         (op),
		.op_valid_o   (op_valid),
		.op_ready_i   (op_ready)
	);

	mem_bus_master i_mem_bus_master (
		.clk          (clk),
		.rst          (rst),
		.op_i         (op),
		.op_valid_i   (op_valid),
		.op_ready_o   (op_ready),
		.bus_o        (bus_o),
		.ack_i        (ack_i),
		.dat_i        (dat_i),
		.resp_o       (resp_o),
		.resp_valid_o (resp_valid_o),
		.resp_ready_i (resp_ready_i)
	);

endmodule

/* mem_bus_master.sv */
// bus master: one single cyc/stb cycle per op, load extension, held response
// faulted ops skip the bus and answer with result 0
// ready only in BM_IDLE, so at most one op is held here at a time

`timescale 1ns/10ps

module mem_bus_master (
	input  logic                        clk,
	input  logic                        rst,
	input  mem_pkg::bus_op_t            op_i,
	input  logic                        op_valid_i,
	output logic                        op_ready_o,
	output mem_pkg::bus_out_t           bus_o,
	input  logic                        ack_i,
	input  logic [mem_pkg::DAT_W-1:0]   dat_i,
	output mem_pkg::mem_resp_t          resp_o,
	output logic                        resp_valid_o,
	input  logic                        resp_ready_i
);

	mem_pkg::bus_state_e state;
	mem_pkg::bus_op_t    op_q;
	mem_pkg::mem_resp_t  resp_q;
	logic                cyc_q;
	logic                take;

	// shift the addressed bytes down and extend by size
	function automatic logic [mem_pkg::DAT_W-1:0] load_ext(
		input mem_pkg::bus_op_t          op,
		input logic [mem_pkg::DAT_W-1:0] word
	);
		logic [mem_pkg::DAT_W-1:0] sh;
		logic                      sx;
		logic [mem_pkg::DAT_W-1:0] res;
		sh = word >> {op.bofs, 3'b000};
		sx = (op.func == mem_pkg::LOAD);
		case (op.size)
			mem_pkg::SZ_B: res = {{56{sx & sh[7]}}, sh[7:0]};
			mem_pkg::SZ_W: res = {{48{sx & sh[15]}}, sh[15:0]};
			mem_pkg::SZ_T: res = {{32{sx & sh[31]}}, sh[31:0]};
			default:       res = sh;
		endcase
		if (op.func == mem_pkg::STORE)
			res = '0;
		return res;
	endfunction

	assign op_ready_o = (state == mem_pkg::BM_IDLE);
	assign take       = op_ready_o && op_valid_i;

	// ==================================================
	// state machine
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mem_pkg::BM_IDLE;
			cyc_q <= 1'b0;
		end else begin
			case (state)
				mem_pkg::BM_IDLE: begin
					if (op_valid_i) begin
						if (op_i.cause != mem_pkg::FLT_NONE) begin
							state <= mem_pkg::BM_RESP;   // no bus cycle
						end else begin
							state <= mem_pkg::BM_CYCLE;
							cyc_q <= 1'b1;
						end
					end
				end
				mem_pkg::BM_CYCLE: begin
					if (ack_i) begin
						state <= mem_pkg::BM_RESP;
						cyc_q <= 1'b0;     // drop on the acking edge
					end
				end
				mem_pkg::BM_RESP: begin
					if (resp_ready_i)
						state <= mem_pkg::BM_IDLE;
				end
				default: begin
					state <= mem_pkg::BM_IDLE;
					cyc_q <= 1'b0;
				end
			endcase
		end
	end

	// ==================================================
	// op and response registers
	// ==================================================
	always_ff @(posedge clk) begin
		if (take) begin
			op_q         <= op_i;
			resp_q.tid   <= op_i.tid;
			resp_q.cause <= op_i.cause;
			resp_q.res   <= '0;     // stays 0 for stores and faults
		end
		if (state == mem_pkg::BM_CYCLE && ack_i)
			resp_q.res <= load_ext(op_q, dat_i);
	end

	// bus outputs, lane and write strobes only inside a cycle
	always_comb begin
		bus_o.cyc = cyc_q;
		bus_o.stb = cyc_q;
		bus_o.we  = cyc_q && (op_q.func == mem_pkg::STORE);
		bus_o.sel = cyc_q ? op_q.sel : '0;
		bus_o.adr = op_q.adr;
		bus_o.dat = op_q.dat;
	end

	assign resp_o       = resp_q;
	assign resp_valid_o = (state == mem_pkg::BM_RESP);

endmodule

/* mem_addr_gen.sv */
// address stage: limit and alignment check, physical address, lanes and store data
// the fault checks use the segment offset, so seg_i.base must be 8-byte aligned
// seg_i must stay stable while requests are pending

`timescale 1ns/10ps

module mem_addr_gen (
	input  logic                 clk,
	input  logic                 rst,
	input  mem_pkg::mem_req_t    head_i,
	input  logic                 head_valid_i,
	output logic                 pop_o,
	input  mem_pkg::seg_desc_t   seg_i,
	output mem_pkg::bus_op_t     op_o,
	output logic                 op_valid_o,
	input  logic                 op_ready_i
);

	logic [mem_pkg::ADR_W-1:0]  phys;
	logic [mem_pkg::BOFS_W-1:0] bofs;
	logic [mem_pkg::BOFS_W+1:0] span;      // bofs plus size in bytes
	logic [mem_pkg::SEL_W-1:0]  size_mask;
	logic [mem_pkg::BOFS_W+1:0] nbytes;
	mem_pkg::mem_cause_e        cause;
	mem_pkg::bus_op_t           op_d;

	// ==================================================
	// checks and formation
	// ==================================================
	always_comb begin
		case (head_i.size)
			mem_pkg::SZ_B: begin
				size_mask = mem_pkg::SEL_W'(8'h01);
				nbytes    = 'd1;
			end
			mem_pkg::SZ_W: begin
				size_mask = mem_pkg::SEL_W'(8'h03);
				nbytes    = 'd2;
			end
			mem_pkg::SZ_T: begin
				size_mask = mem_pkg::SEL_W'(8'h0F);
				nbytes    = 'd4;
			end
			default: begin
				size_mask = mem_pkg::SEL_W'(8'hFF);
				nbytes    = 'd8;
			end
		endcase
	end

	assign bofs = head_i.adr[mem_pkg::BOFS_W-1:0];
	assign span = {2'b00, bofs} + nbytes;
	assign phys = seg_i.base + head_i.adr;

	// limit fault wins over alignment fault
	always_comb begin
		if (head_i.adr > seg_i.limit)
			cause = mem_pkg::FLT_SGB;
		else if (span > (mem_pkg::BOFS_W+2)'(mem_pkg::SEL_W))
			cause = mem_pkg::FLT_ALN;
		else
			cause = mem_pkg::FLT_NONE;
	end

	always_comb begin
		op_d.func  = head_i.func;
		op_d.size  = head_i.size;
		op_d.tid   = head_i.tid;
		op_d.cause = cause;
		op_d.adr   = {phys[mem_pkg::ADR_W-1:mem_pkg::BOFS_W], {mem_pkg::BOFS_W{1'b0}}};
		op_d.sel   = size_mask << bofs;
		op_d.dat   = head_i.dat << {bofs, 3'b000};   // move store data into its lanes
		op_d.bofs  = bofs;
	end

	// ==================================================
	// one-entry output register
	// ==================================================
	assign pop_o = head_valid_i && (!op_valid_o || op_ready_i);

	always_ff @(posedge clk) begin
		if (rst)
			op_valid_o <= 1'b0;
		else if (pop_o)
			op_valid_o <= 1'b1;
		else if (op_ready_i)
			op_valid_o <= 1'b0;      // transferred, nothing new
	end

	always_ff @(posedge clk) begin
		if (pop_o)
			op_o <= op_d;
	end

endmodule

/* mem_req_fifo.sv */
// request FIFO, FIFO_DEPTH entries, head shown on dout_o while valid_o is high
// a write while full is dropped, a read while empty is ignored

`timescale 1ns/10ps

module mem_req_fifo (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wr_i,
	input  mem_pkg::mem_req_t    din_i,
	output logic                 full_o,
	input  logic                 rd_i,
	output mem_pkg::mem_req_t    dout_o,
	output logic                 valid_o
);

	mem_pkg::mem_req_t mem [mem_pkg::FIFO_DEPTH];

	logic [mem_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [mem_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [mem_pkg::FIFO_CNT_W-1:0] count;
	logic                           do_wr;
	logic                           do_rd;

	assign full_o  = (count == mem_pkg::FIFO_CNT_W'(mem_pkg::FIFO_DEPTH));
	assign valid_o = (count != '0);
	assign dout_o  = mem[rd_ptr];

	assign do_wr = wr_i && !full_o;
	assign do_rd = rd_i && valid_o;

	// pointers and fill level
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din_i;
	end

endmodule

/* mem_pkg.sv */
// shared widths, enums and records of the data-side memory request controller
// the 64-bit bus carries eight byte lanes, the segment base must be 8-byte aligned
// FIFO_DEPTH must be a power of two because the FIFO pointers wrap freely

package mem_pkg;

	// ==================================================
	// widths and sizes
	// ==================================================
	localparam int ADR_W      = 32;
	localparam int DAT_W      = 64;
	localparam int SEL_W      = DAT_W / 8;        // byte lanes
	localparam int BOFS_W     = $clog2(SEL_W);    // byte offset within a word
	localparam int TID_W      = 4;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	// ==================================================
	// encodings
	// ==================================================
	typedef enum logic [1:0] {
		LOAD,       // sign-extending load
		LOADZ,      // zero-extending load
		STORE
	} mem_func_e;

	typedef enum logic [1:0] {
		SZ_B,       // byte, 1
		SZ_W,       // wyde, 2
		SZ_T,       // tetra, 4
		SZ_O        // octa, 8
	} mem_size_e;

	typedef enum logic [1:0] {
		FLT_NONE,
		FLT_SGB,    // offset beyond segment limit
		FLT_ALN     // access crosses an 8-byte boundary
	} mem_cause_e;

	typedef enum logic [1:0] {
		BM_IDLE,
		BM_CYCLE,
		BM_RESP
	} bus_state_e;

	// ==================================================
	// records
	// ==================================================
	typedef struct packed {
		mem_func_e              func;
		mem_size_e              size;
		logic [TID_W-1:0]       tid;
		logic [ADR_W-1:0]       adr;    // offset into the segment
		logic [DAT_W-1:0]       dat;    // store data, right aligned
	} mem_req_t;

	typedef struct packed {
		logic [ADR_W-1:0]       base;
		logic [ADR_W-1:0]       limit;  // highest legal offset
	} seg_desc_t;

	// op handed from the address stage to the bus master
	typedef struct packed {
		mem_func_e              func;
		mem_size_e              size;
		logic [TID_W-1:0]       tid;
		mem_cause_e             cause;
		logic [ADR_W-1:0]       adr;    // word aligned physical address
		logic [SEL_W-1:0]       sel;
		logic [DAT_W-1:0]       dat;    // store data in lane position
		logic [BOFS_W-1:0]      bofs;
	} bus_op_t;

	typedef struct packed {
		logic [TID_W-1:0]       tid;
		logic [DAT_W-1:0]       res;
		mem_cause_e             cause;
	} mem_resp_t;

	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [SEL_W-1:0]       sel;
		logic [ADR_W-1:0]       adr;
		logic [DAT_W-1:0]       dat;
	} bus_out_t;

endpackage
